// File: include/hm_defs.svh
`ifndef HM_TX_DEFS_SVH
`define HM_TX_DEFS_SVH

// memory read requester constants

// every request is two 64-bit beats on trn_td
`define HM_TX_BEATS 2

// stall cycles before an unaccepted first beat is dropped
`define HM_TX_TIMEOUT_DEFAULT 65535

// fixed tag, the completer echoes it back in the completion
`define HM_TX_TAG 8'h38

// 32 dw per read, max payload size of the root complex
`define HM_TX_LEN_DW 10'd32

// attr[1:0] is {relaxed ordering, no snoop}
`define HM_TX_ATTR 2'b01

// byte enables, both all ones for a multi dw read
`define HM_TX_FIRST_BE 4'hf
`define HM_TX_LAST_BE 4'hf

`endif

// File: source/hm_pkg.sv
package hm_pkg;

  // requester state
  typedef enum logic {
    HM_STATE_IDLE = 1'b0, // waiting for tx_start
    HM_STATE_SEND = 1'b1  // frame open on trn
  } hm_state_t;

  // tlp fmt field for a read, no data in either case
  typedef enum logic [2:0] {
    HM_FMT_3DW_NODATA = 3'b000, // address below 4 GB
    HM_FMT_4DW_NODATA = 3'b001  // 64-bit address
  } hm_fmt_t;

  // memory read type field
  localparam logic [4:0] HM_TYPE_MRD = 5'b00000;

  // one trn data beat, dw0 in the upper half
  typedef logic [63:0] hm_beat_t;

endpackage

// File: source/hm_tx_fsm.sv
`timescale 1ns/1ps

module hm_tx_fsm import hm_pkg::*; (
  input  logic      trn_clk,
  input  logic      rst,
  input  logic      tx_start,
  input  logic      trn_tdst_rdy_n,
  input  logic      last_beat,     // beat 1 on the bus
  input  logic      first_done,    // beat 0 already accepted
  input  logic      expired,       // stall limit hit at this edge
  output logic      tx_end,
  output logic      timeout,
  output logic      trn_cyc_n,
  output logic      trn_tsrc_rdy_n,
  output logic      trn_tsof_n,
  output logic      trn_teof_n,
  output logic      load,          // latch address and header
  output logic      advance,       // switch trn_td to beat 1
  output logic      clear,         // frame over, back to zero
  output logic      count_en,      // stall cycle on beat 0
  output logic      beat_inc,      // beat accepted
  output logic      sent,          // frame completed
  output logic      timed_out,     // frame dropped
  output hm_state_t stat_state
);

  hm_state_t state;
  logic      accept;

  // a beat moves when both ready strobes are low at the edge
  assign accept = (state == HM_STATE_SEND) && !trn_tsrc_rdy_n && !trn_tdst_rdy_n;

  assign load      = (state == HM_STATE_IDLE) && tx_start; // start ignored while busy
  assign beat_inc  = accept;
  assign advance   = accept && !last_beat;
  assign sent      = accept && last_beat;

  // stalls only count until beat 0 goes through
  assign count_en  = (state == HM_STATE_SEND) && trn_tdst_rdy_n && !first_done;

  // once beat 0 is out the frame must finish, no half frame on the link
  assign timed_out = expired && !first_done;

  assign clear      = sent || timed_out;
  assign stat_state = state;

  always_ff @(posedge trn_clk) begin
    if (rst) begin
      state          <= HM_STATE_IDLE;
      tx_end         <= 1'b0;
      timeout        <= 1'b0;
      trn_cyc_n      <= 1'b1;
      trn_tsrc_rdy_n <= 1'b1;
      trn_tsof_n     <= 1'b1;
      trn_teof_n     <= 1'b1;
    end else begin
      tx_end  <= sent;      // one cycle pulses
      timeout <= timed_out;
      case (state)
        HM_STATE_IDLE: begin
          if (load) begin
            // present beat 0 right away
            state          <= HM_STATE_SEND;
            trn_cyc_n      <= 1'b0;
            trn_tsrc_rdy_n <= 1'b0;
            trn_tsof_n     <= 1'b0;
            trn_teof_n     <= 1'b1;
          end
        end
        HM_STATE_SEND: begin
          if (sent || timed_out) begin
            // close the frame, all strobes back high
            state          <= HM_STATE_IDLE;
            trn_cyc_n      <= 1'b1;
            trn_tsrc_rdy_n <= 1'b1;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
          end else if (advance) begin
            trn_tsof_n <= 1'b1; // beat 1 is the last one
            trn_teof_n <= 1'b0;
          end
        end
        default: state <= HM_STATE_IDLE;
      endcase
    end
  end

endmodule

// File: source/hm_tx_timer.sv
`timescale 1ns/1ps
`include "hm_defs.svh"

module hm_tx_timer #(
  parameter int unsigned timeout_cycles = `HM_TX_TIMEOUT_DEFAULT
) (
  input  logic trn_clk,
  input  logic rst,
  input  logic clear,     // frame finished or dropped
  input  logic count_en,  // beat 0 stalled this cycle
  input  logic beat_inc,  // beat accepted this cycle
  output logic last_beat,
  output logic first_done,
  output logic expired
);

  // at least one bit even for a single beat frame
  localparam int beat_w = ($clog2(`HM_TX_BEATS) > 0) ? $clog2(`HM_TX_BEATS) : 1;

  logic [beat_w-1:0] beat_idx;  // beat currently on trn_td
  logic [31:0]       stall_cnt; // stall cycles on beat 0

  always_ff @(posedge trn_clk) begin
    if (rst || clear) begin
      beat_idx  <= '0;
      stall_cnt <= '0;
    end else begin
      if (beat_inc) begin
        beat_idx <= beat_idx + 1'b1;
      end
      if (count_en) begin
        stall_cnt <= stall_cnt + 1'b1;
      end
    end
  end

  assign last_beat  = (beat_idx == beat_w'(`HM_TX_BEATS - 1));
  assign first_done = (beat_idx != '0);

  // count reaches the limit at this edge
  assign expired = count_en && (stall_cnt == 32'(timeout_cycles - 1));

endmodule

// File: source/hm_tx_hdr.sv
`timescale 1ns/1ps
`include "hm_defs.svh"

module hm_tx_hdr import hm_pkg::*; (
  input  logic        trn_clk,
  input  logic        rst,
  input  logic        load,     // start of request
  input  logic        advance,  // beat 0 accepted
  input  logic        clear,    // frame closed
  input  logic [63:0] hm_addr,
  input  logic [7:0]  cfg_bus_number,
  input  logic [4:0]  cfg_device_number,
  input  logic [2:0]  cfg_function_number,
  output hm_beat_t    trn_td,
  output logic        trn_trem_n
);

  hm_fmt_t     fmt;
  logic [15:0] req_id;
  hm_beat_t    beat0;
  hm_beat_t    beat1;
  hm_beat_t    beat1_q;  // held until beat 0 goes through
  logic        rem_n_q;

  // 3 dw header whenever the upper address word is zero
  assign fmt = (hm_addr[63:32] == 32'h0) ? HM_FMT_3DW_NODATA : HM_FMT_4DW_NODATA;

  assign req_id = {cfg_bus_number, cfg_device_number, cfg_function_number};

  // dw0 and dw1 of the request header
  assign beat0 = {
    fmt,              // fmt
    HM_TYPE_MRD,      // type, memory read
    8'h00,            // reserved, tc 0, reserved
    2'b00,            // td, ep
    `HM_TX_ATTR,      // no snoop
    2'b00,            // at, untranslated
    `HM_TX_LEN_DW,    // length in dw
    req_id,
    `HM_TX_TAG,
    `HM_TX_LAST_BE,
    `HM_TX_FIRST_BE
  };

  // dw2 (and dw3), low address bits are dw aligned
  assign beat1 = (fmt == HM_FMT_3DW_NODATA) ? {hm_addr[31:2], 2'b00, 32'h0}
                                             : {hm_addr[63:2], 2'b00};

  // second beat and its remainder flag kept aside until beat 0 is accepted
  always_ff @(posedge trn_clk) begin
    if (load) begin
      beat1_q <= beat1;
      rem_n_q <= (fmt == HM_FMT_3DW_NODATA); // only upper dw valid on 3 dw
    end
  end

  always_ff @(posedge trn_clk) begin
    if (rst || clear) begin
      trn_td     <= '0;
      trn_trem_n <= 1'b1;
    end else if (load) begin
      trn_td     <= beat0;
      trn_trem_n <= 1'b1;
    end else if (advance) begin
      trn_td     <= beat1_q;
      trn_trem_n <= rem_n_q;
    end
  end

endmodule

// File: source/hm_tx_stats.sv
`timescale 1ns/1ps

module hm_tx_stats (
  input  logic        trn_clk,
  input  logic        rst,
  input  logic        sent,            // frame completed
  input  logic        timed_out,       // frame dropped on stall
  input  logic        trn_terr_drop_n, // core dropped a tlp
  output logic [31:0] stat_trn_cpt_tx,
  output logic [31:0] stat_trn_cpt_drop,
  output logic [31:0] stat_trn_cpt_timeout
);

  // all three wrap on overflow
  always_ff @(posedge trn_clk) begin
    if (rst) begin
      stat_trn_cpt_tx      <= '0;
      stat_trn_cpt_drop    <= '0;
      stat_trn_cpt_timeout <= '0;
    end else begin
      if (sent) begin
        stat_trn_cpt_tx <= stat_trn_cpt_tx + 1'b1;
      end
      // drop flag counted in any state, once per cycle low
      if (!trn_terr_drop_n) begin
        stat_trn_cpt_drop <= stat_trn_cpt_drop + 1'b1;
      end
      if (timed_out) begin
        stat_trn_cpt_timeout <= stat_trn_cpt_timeout + 1'b1;
      end
    end
  end

endmodule

// File: source/hm_tx.sv
`timescale 1ns/1ps
`include "hm_defs.svh"

module hm_tx import hm_pkg::*; #(
  parameter int unsigned timeout_cycles = `HM_TX_TIMEOUT_DEFAULT
) (
  input  logic        trn_clk,
  input  logic        rst,
  input  logic        tx_start,
  output logic        tx_end,
  output logic        timeout,
  input  logic [63:0] hm_addr,
  input  logic [7:0]  cfg_bus_number,
  input  logic [4:0]  cfg_device_number,
  input  logic [2:0]  cfg_function_number,
  // trn transmit side of the core
  output logic        trn_cyc_n,
  output hm_beat_t    trn_td,
  output logic        trn_tsof_n,
  output logic        trn_teof_n,
  output logic        trn_trem_n,
  output logic        trn_tsrc_rdy_n,
  input  logic        trn_tdst_rdy_n,
  input  logic        trn_terr_drop_n,
  // statistics and status
  output logic [31:0] stat_trn_cpt_tx,
  output logic [31:0] stat_trn_cpt_drop,
  output logic [31:0] stat_trn_cpt_timeout,
  output hm_state_t   stat_state
);

  logic load, advance, clear;              // fsm to header
  logic count_en, beat_inc;                // fsm to timer
  logic last_beat, first_done, expired;    // timer back to fsm
  logic sent, timed_out;                   // fsm to stats

  hm_tx_fsm fsm0 (
    .trn_clk, .rst, .tx_start, .trn_tdst_rdy_n,
    .last_beat, .first_done, .expired,
    .tx_end, .timeout,
    .trn_cyc_n, .trn_tsrc_rdy_n, .trn_tsof_n, .trn_teof_n,
    .load, .advance, .clear, .count_en, .beat_inc,
    .sent, .timed_out, .stat_state
  );

  hm_tx_timer #(.timeout_cycles(timeout_cycles)) timer0 (
    .trn_clk, .rst, .clear, .count_en, .beat_inc,
    .last_beat, .first_done, .expired
  );

  hm_tx_hdr hdr0 (
    .trn_clk, .rst, .load, .advance, .clear, .hm_addr,
    .cfg_bus_number, .cfg_device_number, .cfg_function_number,
    .trn_td, .trn_trem_n
  );

  hm_tx_stats stats0 (
    .trn_clk, .rst, .sent, .timed_out, .trn_terr_drop_n,
    .stat_trn_cpt_tx, .stat_trn_cpt_drop, .stat_trn_cpt_timeout
  );

endmodule

// File: tests/hm_tx_clkgen.sv
`timescale 1ns/1ps

module hm_tx_clkgen #(
  parameter real period_ns    = 40.0,
  parameter int  reset_cycles = 10
) (
  output logic trn_clk,
  output logic rst
);

  initial begin
    trn_clk = 1'b0;
    forever #(period_ns / 2.0) trn_clk = ~trn_clk;
  end

  // reset released on a rising edge, like any other tb input
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge trn_clk);
    rst <= 1'b0;
  end

endmodule

// File: tests/hm_tx_checker.sv
`timescale 1ns/1ps

module hm_tx_checker (
  input logic        trn_clk,
  input logic        rst,
  input logic        trn_cyc_n,
  input logic        trn_tsrc_rdy_n,
  input logic        trn_tdst_rdy_n,
  input logic        trn_tsof_n,
  input logic        trn_teof_n,
  input logic [63:0] trn_td,
  input logic        tx_end,
  input logic        timeout,
  input logic        timed_out   // frame dropped at this edge
);

  int fail_count = 0; // failed assertions so far

  a_cyc: assert property (@(posedge trn_clk) disable iff (rst)
    !trn_tsrc_rdy_n |-> !trn_cyc_n)
    else begin
      $error("trn_tsrc_rdy_n low outside trn_cyc_n");
      fail_count++;
    end

  a_end: assert property (@(posedge trn_clk) disable iff (rst) tx_end |=> !tx_end)
    else begin
      $error("tx_end longer than one cycle");
      fail_count++;
    end

  a_timeout: assert property (@(posedge trn_clk) disable iff (rst) timeout |=> !timeout)
    else begin
      $error("timeout longer than one cycle");
      fail_count++;
    end

  a_sof_eof: assert property (@(posedge trn_clk) disable iff (rst)
    !(!trn_tsof_n && !trn_teof_n))
    else begin
      $error("trn_tsof_n and trn_teof_n low together");
      fail_count++;
    end

  // a dropped frame clears trn_td, so that edge is left out
  a_stable: assert property (@(posedge trn_clk) disable iff (rst)
    (!trn_tsrc_rdy_n && trn_tdst_rdy_n && !timed_out) |=> $stable(trn_td))
    else begin
      $error("trn_td changed during a stalled beat");
      fail_count++;
    end

endmodule

bind hm_tx hm_tx_checker chk0 (
  .trn_clk(trn_clk), .rst(rst), .trn_cyc_n(trn_cyc_n), .trn_tsrc_rdy_n(trn_tsrc_rdy_n),
  .trn_tdst_rdy_n(trn_tdst_rdy_n), .trn_tsof_n(trn_tsof_n), .trn_teof_n(trn_teof_n),
  .trn_td(trn_td), .tx_end(tx_end), .timeout(timeout), .timed_out(timed_out)
);

// File: tests/hm_tx_tb.sv
`timescale 1ns/1ps
`include "hm_defs.svh"

module hm_tx_tb import hm_pkg::*; ();

  localparam int n3 = 6; // 3 dw requests
  localparam int n4 = 6; // 4 dw requests under back-pressure
  localparam int max_cycles = 2 * (12 + n3 * 10 + n4 * 45 + 30 + 40 + 20 + 30);
  localparam int BP_READY = 0, BP_HOLD = 1, BP_RANDOM = 2, BP_AFTER_SOF = 3;

  logic        trn_clk, rst;
  logic        tx_start = 1'b0;
  logic [63:0] hm_addr = '0;
  logic [7:0]  cfg_bus_number = '0;
  logic [4:0]  cfg_device_number = '0;
  logic [2:0]  cfg_function_number = '0;
  logic        trn_tdst_rdy_n = 1'b1;
  logic        trn_terr_drop_n = 1'b1;
  logic        tx_end, timeout, trn_cyc_n, trn_tsof_n, trn_teof_n, trn_trem_n, trn_tsrc_rdy_n;
  hm_beat_t    trn_td;
  logic [31:0] stat_trn_cpt_tx, stat_trn_cpt_drop, stat_trn_cpt_timeout;
  hm_state_t   stat_state;

  logic [31:0]  stim_seed = 32'd95701;
  logic [31:0]  bp_seed = 32'd95701;
  int           bp_mode = BP_READY;
  int           stall_left = 0;
  int           value_errs = 0, other_errs = 0, cycle_cnt = 0;
  int           frames_done = 0, aborts = 0, drops_driven = 0, beats_seen = 0;
  string        test_name = "reset";
  logic [128:0] exp_q[$]; // {beat0, beat1, trem_n}
  logic [66:0]  got_q[$]; // {td, tsof_n, teof_n, trem_n}

  hm_tx_clkgen #(.period_ns(40.0), .reset_cycles(10)) clk0 (.trn_clk, .rst);

  hm_tx #(.timeout_cycles(16)) dut0 (.*);

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_seed = lfsr_next(stim_seed);
      v = {v[62:0], stim_seed[0]};
    end
  endtask

  // wrong value, the line starts with ERR
  task automatic mismatch_seen(input string line);
    $display("%s", line);
    value_errs++;
  endtask

  // anything else that went wrong
  task automatic failure_seen(input string line);
    $display("%s", line);
    other_errs++;
  endtask

  // expected beats from the memory read header layout
  function automatic logic [128:0] ref_frame(input logic [63:0] addr, input logic [7:0] bus,
                                             input logic [4:0] dev, input logic [2:0] fn);
    logic        four_dw;
    logic [31:0] dw0, dw1;
    logic [63:0] b1;
    four_dw = (addr[63:32] != 32'h0);
    dw0 = {2'b00, four_dw, 5'b00000, 1'b0, 3'b000, 4'h0, 2'b00, `HM_TX_ATTR, 2'b00,
           `HM_TX_LEN_DW};
    dw1 = {bus, dev, fn, `HM_TX_TAG, 4'hf, 4'hf};
    b1 = four_dw ? {addr[63:2], 2'b00} : {addr[31:2], 2'b00, 32'h0};
    return {dw0, dw1, b1, !four_dw};
  endfunction

  // core ready strobe, stall runs stay below the abort limit in random mode
  always @(posedge trn_clk) begin : drive_ready
    logic [3:0] len;
    if (rst) begin
      trn_tdst_rdy_n <= 1'b1;
      stall_left <= 0;
    end else if (stall_left != 0) begin
      trn_tdst_rdy_n <= 1'b1;
      stall_left <= stall_left - 1;
    end else begin
      case (bp_mode)
        BP_HOLD: trn_tdst_rdy_n <= 1'b1;
        BP_RANDOM: begin
          bp_seed = lfsr_next(bp_seed);
          if (trn_tdst_rdy_n || !bp_seed[0]) begin
            trn_tdst_rdy_n <= 1'b0; // one ready cycle after every run
          end else begin
            for (int i = 0; i < 4; i++) begin
              bp_seed = lfsr_next(bp_seed);
              len = {len[2:0], bp_seed[0]};
            end
            trn_tdst_rdy_n <= (len == 0) ? 1'b0 : 1'b1;
            stall_left <= (len == 0) ? 0 : len - 1;
          end
        end
        BP_AFTER_SOF: begin
          if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n && !trn_tsof_n) begin
            trn_tdst_rdy_n <= 1'b1; // long stall on beat 1
            stall_left <= 19;
          end else begin
            trn_tdst_rdy_n <= 1'b0;
          end
        end
        default: trn_tdst_rdy_n <= 1'b0;
      endcase
    end
  end

  always @(posedge trn_clk) begin : capture_beats
    if (!rst && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
      got_q.push_back({trn_td, trn_tsof_n, trn_teof_n, trn_trem_n});
      beats_seen++;
    end
  end

  always @(negedge trn_clk) begin : compare_frames
    logic [128:0] e;
    logic [66:0]  g0, g1;
    if (got_q.size() >= 2) begin
      g0 = got_q.pop_front();
      g1 = got_q.pop_front();
      assert (exp_q.size() != 0)
        else failure_seen($sformatf("%s: frame accepted with no request pending", test_name));
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (g0[66:3] == e[128:65])
          else mismatch_seen($sformatf("ERR %s beat0 exp %h got %h",
                                       test_name, e[128:65], g0[66:3]));
        assert (g1[66:3] == e[64:1])
          else mismatch_seen($sformatf("ERR %s beat1 exp %h got %h",
                                       test_name, e[64:1], g1[66:3]));
        assert (g0[2:1] == 2'b01 && g1[2:1] == 2'b10) // sof_n, eof_n per beat
          else mismatch_seen($sformatf("ERR %s sof/eof exp 0110 got %b%b",
                                       test_name, g0[2:1], g1[2:1]));
        assert (g1[0] == e[0])
          else mismatch_seen($sformatf("ERR %s trem_n exp %b got %b",
                                       test_name, e[0], g1[0]));
      end
    end
  end

  always @(posedge trn_clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("run stopped after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic start_request(input logic [63:0] addr, input bit expect_frame);
    logic [63:0] r;
    rand_bits(16, r);
    @(posedge trn_clk);
    hm_addr <= addr;
    cfg_bus_number <= r[15:8];
    cfg_device_number <= r[7:3];
    cfg_function_number <= r[2:0];
    tx_start <= 1'b1;
    if (expect_frame) exp_q.push_back(ref_frame(addr, r[15:8], r[7:3], r[2:0]));
    @(posedge trn_clk); // start edge
    tx_start <= 1'b0;
  endtask

  // edges counts negedges from the start edge on, so latency is edges - 1
  task automatic wait_done(input bit want_end, output int edges);
    edges = 0;
    do begin
      @(negedge trn_clk);
      edges++;
    end while (!tx_end && !timeout && edges < 400);
    assert (edges < 400)
      else failure_seen($sformatf("%s: DUT gave neither tx_end nor timeout", test_name));
    assert (tx_end == want_end && timeout == !want_end)
      else mismatch_seen($sformatf("ERR %s end exp %b got end %b timeout %b",
                                   test_name, want_end, tx_end, timeout));
    if (want_end) frames_done++; // tallies of what each request should do
    else aborts++;
  endtask

  task automatic drop_cycles(input int n);
    @(posedge trn_clk);
    trn_terr_drop_n <= 1'b0;
    repeat (n) @(posedge trn_clk);
    trn_terr_drop_n <= 1'b1;
    drops_driven += n;
    @(negedge trn_clk); // step off the edge before the next test
  endtask

  initial begin : run_tests
    logic [63:0] a;
    int          edges, beats_before;
    @(negedge trn_clk);
    while (rst) @(negedge trn_clk);
    assert (trn_cyc_n && trn_tsrc_rdy_n && trn_tsof_n && trn_teof_n && !tx_end && !timeout
            && trn_td == 0 && stat_state == HM_STATE_IDLE)
      else failure_seen($sformatf("%s: outputs not at rest after reset", test_name));
    assert (stat_trn_cpt_tx == 0 && stat_trn_cpt_drop == 0 && stat_trn_cpt_timeout == 0)
      else failure_seen($sformatf("%s: counters not cleared", test_name));

    test_name = "mrd_3dw";
    for (int i = 0; i < n3; i++) begin
      rand_bits(32, a);
      start_request({32'h0, a[31:0]}, 1'b1);
      wait_done(1'b1, edges);
      assert (edges - 1 == 2)
        else mismatch_seen($sformatf("ERR %s latency exp 2 got %0d", test_name, edges - 1));
    end

    test_name = "mrd_4dw_backpressure";
    bp_mode = BP_RANDOM;
    for (int i = 0; i < n4; i++) begin
      rand_bits(64, a);
      start_request(a | 64'h1_0000_0000, 1'b1);
      wait_done(1'b1, edges);
    end
    bp_mode = BP_READY;
    drop_cycles(5);

    test_name = "abort_on_stall";
    bp_mode = BP_HOLD;
    beats_before = beats_seen;
    start_request(64'h0000_0000_8000_0100, 1'b0);
    wait_done(1'b0, edges);
    assert (beats_seen == beats_before)
      else mismatch_seen($sformatf("ERR %s beats exp %0d got %0d",
                                   test_name, beats_before, beats_seen));
    bp_mode = BP_READY;
    repeat (3) @(negedge trn_clk);

    test_name = "long_stall_beat1";
    bp_mode = BP_AFTER_SOF;
    start_request(64'h0000_0012_3456_7894, 1'b1);
    wait_done(1'b1, edges);
    assert (edges - 1 > 20)
      else mismatch_seen($sformatf("ERR %s latency exp >20 got %0d", test_name, edges - 1));
    bp_mode = BP_READY;

    test_name = "start_while_busy";
    beats_before = beats_seen;
    start_request(64'h0000_0000_0000_4000, 1'b1);
    tx_start <= 1'b1; // seen while the frame is open
    @(posedge trn_clk);
    @(posedge trn_clk);
    tx_start <= 1'b0;
    wait_done(1'b1, edges);
    repeat (6) @(negedge trn_clk);
    assert (beats_seen == beats_before + 2 && stat_state == HM_STATE_IDLE)
      else mismatch_seen($sformatf("ERR %s beats exp %0d got %0d",
                                   test_name, beats_before + 2, beats_seen));
    drop_cycles(3);
    repeat (3) @(negedge trn_clk);

    test_name = "statistics";
    assert (stat_trn_cpt_tx == frames_done)
      else mismatch_seen($sformatf("ERR %s tx exp %0d got %0d",
                                   test_name, frames_done, stat_trn_cpt_tx));
    assert (stat_trn_cpt_timeout == aborts)
      else mismatch_seen($sformatf("ERR %s timeout exp %0d got %0d",
                                   test_name, aborts, stat_trn_cpt_timeout));
    assert (stat_trn_cpt_drop == drops_driven)
      else mismatch_seen($sformatf("ERR %s drop exp %0d got %0d",
                                   test_name, drops_driven, stat_trn_cpt_drop));
    assert (exp_q.size() == 0 && got_q.size() == 0)
      else failure_seen($sformatf("%s: frames left unmatched at the end", test_name));

    $display("errors: value %0d, other %0d, checker %0d", value_errs, other_errs,
             dut0.chk0.fail_count);
    if (value_errs == 0 && other_errs == 0 && dut0.chk0.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
source/hm_pkg.sv
source/hm_tx_fsm.sv
source/hm_tx_timer.sv
source/hm_tx_hdr.sv
source/hm_tx_stats.sv
source/hm_tx.sv
tests/hm_tx_clkgen.sv
tests/hm_tx_checker.sv
tests/hm_tx_tb.sv
